/* lsu_pkg.sv */
// -------------------------------------------------------------------------
// LSU package
// Widths, operation encoding, exception codes and port structs
// -------------------------------------------------------------------------
package lsu_pkg;

  localparam int unsigned XLEN          = 32;
  localparam int unsigned TRANS_ID_BITS = 3;

  typedef logic [XLEN-1:0]          word_t;
  typedef logic [XLEN/8-1:0]        be_t;
  typedef logic [TRANS_ID_BITS-1:0] trans_id_t;
  typedef logic [3:0]               cause_t;

  typedef enum logic [2:0] {
    LB,
    LBU,
    LH,
    LHU,
    LW,
    SB,
    SH,
    SW
  } lsu_op_e;

  // Exception cause codes
  localparam cause_t LD_ADDR_MISALIGNED = 4'd4;
  localparam cause_t ST_ADDR_MISALIGNED = 4'd6;

  typedef struct packed {
    logic   valid;
    cause_t cause;
    word_t  tval;
  } exception_t;

  // Issue side request, operand_b carries the store data
  typedef struct packed {
    lsu_op_e   operation;
    word_t     operand_a;
    word_t     operand_b;
    word_t     imm;
    trans_id_t trans_id;
  } fu_data_t;

  typedef struct packed {
    logic       valid;
    word_t      vaddr;
    word_t      wdata;
    be_t        be;
    lsu_op_e    operation;
    trans_id_t  trans_id;
    exception_t ex;
  } lsu_ctrl_t;

  typedef struct packed {
    logic       valid;
    trans_id_t  trans_id;
    word_t      result;
    exception_t ex;
  } lsu_result_t;

  // ---------------------------------------------------------------------
  // Data memory ports
  // ---------------------------------------------------------------------
  typedef struct packed {
    logic  req;
    word_t addr;
  } mem_rd_req_t;

  typedef struct packed {
    logic  gnt;
    word_t rdata;
  } mem_rd_rsp_t;

  typedef struct packed {
    logic  req;
    word_t addr;
    be_t   be;
    word_t wdata;
  } mem_wr_req_t;

  function automatic logic op_is_store(lsu_op_e op);
    return (op == SB) || (op == SH) || (op == SW);
  endfunction

endpackage

/* lsu_agu.sv */
// -------------------------------------------------------------------------
// Address generation unit
// Computes the access address, byte enables and misalignment exception
// -------------------------------------------------------------------------
module lsu_agu (
  input  lsu_pkg::fu_data_t  fu_data_i,
  input  logic               valid_i,
  output lsu_pkg::lsu_ctrl_t lsu_req_o
);

  lsu_pkg::word_t      vaddr;
  lsu_pkg::be_t        be;
  logic                misaligned;
  lsu_pkg::exception_t ex;

  // Immediate arrives already sign-extended to XLEN
  assign vaddr = lsu_pkg::word_t'($signed(fu_data_i.operand_a) + $signed(fu_data_i.imm));

  // ---------------------------------------------------------------------
  // Byte enables and alignment check by access size
  // ---------------------------------------------------------------------
  always_comb begin
    be         = '1;
    misaligned = 1'b0;
    case (fu_data_i.operation)
      lsu_pkg::LB, lsu_pkg::LBU, lsu_pkg::SB: begin
        be = lsu_pkg::be_t'(1) << vaddr[1:0];
      end
      lsu_pkg::LH, lsu_pkg::LHU, lsu_pkg::SH: begin
        be         = lsu_pkg::be_t'(3) << vaddr[1:0];
        misaligned = vaddr[0];
      end
      // Word access
      default: begin
        be         = '1;
        misaligned = (vaddr[1:0] != 2'b00);
      end
    endcase
  end

  always_comb begin
    ex = '0;
    if (misaligned) begin
      ex.valid = 1'b1;
      ex.cause = lsu_pkg::op_is_store(fu_data_i.operation) ?
                 lsu_pkg::ST_ADDR_MISALIGNED : lsu_pkg::LD_ADDR_MISALIGNED;
      ex.tval  = vaddr;
    end
  end

  always_comb begin
    lsu_req_o.valid     = valid_i;
    lsu_req_o.vaddr     = vaddr;
    lsu_req_o.wdata     = fu_data_i.operand_b;
    lsu_req_o.be        = be;
    lsu_req_o.operation = fu_data_i.operation;
    lsu_req_o.trans_id  = fu_data_i.trans_id;
    lsu_req_o.ex        = ex;
  end

endmodule

/* lsu_bypass.sv */
// -------------------------------------------------------------------------
// Request queue
// Two entries, an incoming request bypasses the queue while it is empty
// -------------------------------------------------------------------------
module lsu_bypass (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  lsu_pkg::lsu_ctrl_t lsu_req_i,
  input  logic               lsu_req_valid_i,
  input  logic               pop_ld_i,
  input  logic               pop_st_i,
  output lsu_pkg::lsu_ctrl_t lsu_ctrl_o,
  output logic               ready_o
);

  lsu_pkg::lsu_ctrl_t mem_q [2];
  logic               rd_ptr_q;
  logic               wr_ptr_q;
  logic [1:0]         count_q;
  logic               pop;
  logic               empty;
  logic               push;

  assign pop   = pop_ld_i | pop_st_i;
  assign empty = (count_q == 2'd0);

  // A request consumed in its own cycle never enters the queue
  assign push = lsu_req_valid_i & ~(empty & pop);

  assign lsu_ctrl_o = empty ? lsu_req_i : mem_q[rd_ptr_q];
  assign ready_o    = (count_q != 2'd2);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= 1'b0;
      wr_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop && !empty) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      if (push && !(pop && !empty)) begin
        count_q <= count_q + 2'd1;
      end else if (!push && pop && !empty) begin
        count_q <= count_q - 2'd1;
      end
    end
  end

  // Entry storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= lsu_req_i;
    end
  end

endmodule

/* load_unit.sv */
// -------------------------------------------------------------------------
// Load unit
// Issues word reads and aligns and extends the returned data
// -------------------------------------------------------------------------
module load_unit (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 valid_i,
  input  lsu_pkg::lsu_ctrl_t   lsu_ctrl_i,
  output logic                 pop_ld_o,
  output lsu_pkg::mem_rd_req_t mem_rd_req_o,
  input  lsu_pkg::mem_rd_rsp_t mem_rd_rsp_i,
  output lsu_pkg::lsu_result_t result_o
);

  logic                valid_q;
  lsu_pkg::exception_t ex_q;
  lsu_pkg::lsu_op_e    op_q;
  logic [1:0]          off_q;
  lsu_pkg::trans_id_t  id_q;
  lsu_pkg::word_t      shifted;
  lsu_pkg::word_t      ld_data;

  // Exceptions skip memory and retire right away
  assign mem_rd_req_o.req  = valid_i & ~lsu_ctrl_i.ex.valid;
  assign mem_rd_req_o.addr = {lsu_ctrl_i.vaddr[lsu_pkg::XLEN-1:2], 2'b00};
  assign pop_ld_o          = valid_i & (lsu_ctrl_i.ex.valid | mem_rd_rsp_i.gnt);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      ex_q    <= '0;
    end else begin
      valid_q <= pop_ld_o;
      ex_q    <= lsu_ctrl_i.ex;
    end
  end

  // Access details kept for the data return cycle
  always_ff @(posedge clk_i) begin
    if (pop_ld_o) begin
      op_q  <= lsu_ctrl_i.operation;
      off_q <= lsu_ctrl_i.vaddr[1:0];
      id_q  <= lsu_ctrl_i.trans_id;
    end
  end

  // ---------------------------------------------------------------------
  // Data alignment and extension
  // ---------------------------------------------------------------------
  always_comb begin
    shifted = mem_rd_rsp_i.rdata >> {off_q, 3'b000};
    case (op_q)
      lsu_pkg::LB:  ld_data = {{(lsu_pkg::XLEN-8){shifted[7]}}, shifted[7:0]};
      lsu_pkg::LBU: ld_data = {{(lsu_pkg::XLEN-8){1'b0}}, shifted[7:0]};
      lsu_pkg::LH:  ld_data = {{(lsu_pkg::XLEN-16){shifted[15]}}, shifted[15:0]};
      lsu_pkg::LHU: ld_data = {{(lsu_pkg::XLEN-16){1'b0}}, shifted[15:0]};
      default:      ld_data = mem_rd_rsp_i.rdata;
    endcase
  end

  always_comb begin
    result_o.valid    = valid_q;
    result_o.trans_id = id_q;
    result_o.result   = ex_q.valid ? '0 : ld_data;
    result_o.ex       = ex_q;
  end

endmodule

/* store_unit.sv */
// -------------------------------------------------------------------------
// Store unit
// Issues byte-lane aligned writes and reports completion
// -------------------------------------------------------------------------
module store_unit (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 valid_i,
  input  lsu_pkg::lsu_ctrl_t   lsu_ctrl_i,
  output logic                 pop_st_o,
  output lsu_pkg::mem_wr_req_t mem_wr_req_o,
  input  logic                 mem_wr_gnt_i,
  output lsu_pkg::lsu_result_t result_o
);

  logic                valid_q;
  lsu_pkg::exception_t ex_q;
  lsu_pkg::trans_id_t  id_q;

  // Held until granted, the request comes straight from the queue head
  assign mem_wr_req_o.req   = valid_i & ~lsu_ctrl_i.ex.valid;
  assign mem_wr_req_o.addr  = {lsu_ctrl_i.vaddr[lsu_pkg::XLEN-1:2], 2'b00};
  assign mem_wr_req_o.be    = lsu_ctrl_i.be;
  assign mem_wr_req_o.wdata = lsu_ctrl_i.wdata << {lsu_ctrl_i.vaddr[1:0], 3'b000};

  assign pop_st_o = valid_i & (lsu_ctrl_i.ex.valid | mem_wr_gnt_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      ex_q    <= '0;
    end else begin
      valid_q <= pop_st_o;
      ex_q    <= lsu_ctrl_i.ex;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop_st_o) begin
      id_q <= lsu_ctrl_i.trans_id;
    end
  end

  // Stores return no data
  assign result_o.valid    = valid_q;
  assign result_o.trans_id = id_q;
  assign result_o.result   = '0;
  assign result_o.ex       = ex_q;

endmodule

/* lsu_out_pipe.sv */
// -------------------------------------------------------------------------
// Result pipeline of Depth registers, a feed-through at Depth zero
// -------------------------------------------------------------------------
module lsu_out_pipe #(
  parameter int unsigned Depth = 1
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  lsu_pkg::lsu_result_t d_i,
  output lsu_pkg::lsu_result_t d_o
);

  if (Depth == 0) begin : gen_pass
    assign d_o = d_i;
  end else begin : gen_regs
    lsu_pkg::lsu_result_t pipe_q [Depth];

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        for (int i = 0; i < Depth; i++) begin
          pipe_q[i] <= '0;
        end
      end else begin
        pipe_q[0] <= d_i;
        for (int i = 1; i < Depth; i++) begin
          pipe_q[i] <= pipe_q[i-1];
        end
      end
    end

    assign d_o = pipe_q[Depth-1];
  end

endmodule

/* load_store_unit.sv */
// -------------------------------------------------------------------------
// Load/store unit top level
// Address stage, request queue, load and store units, result pipes
// -------------------------------------------------------------------------
module load_store_unit #(
  parameter int unsigned NrLoadPipeRegs  = 1,
  parameter int unsigned NrStorePipeRegs = 1
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 lsu_valid_i,
  input  lsu_pkg::fu_data_t    fu_data_i,
  output logic                 lsu_ready_o,
  output lsu_pkg::lsu_result_t load_o,
  output lsu_pkg::lsu_result_t store_o,
  output lsu_pkg::mem_rd_req_t mem_rd_req_o,
  input  lsu_pkg::mem_rd_rsp_t mem_rd_rsp_i,
  output lsu_pkg::mem_wr_req_t mem_wr_req_o,
  input  logic                 mem_wr_gnt_i
);

  logic                 accept;
  lsu_pkg::lsu_ctrl_t   lsu_req;
  lsu_pkg::lsu_ctrl_t   lsu_ctrl;
  logic                 pop_ld;
  logic                 pop_st;
  logic                 ld_valid;
  logic                 st_valid;
  lsu_pkg::lsu_result_t ld_result;
  lsu_pkg::lsu_result_t st_result;

  assign accept = lsu_valid_i & lsu_ready_o;

  lsu_agu i_lsu_agu (
    .fu_data_i (fu_data_i),
    .valid_i   (accept),
    .lsu_req_o (lsu_req)
  );

  lsu_bypass i_lsu_bypass (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .lsu_req_i       (lsu_req),
    .lsu_req_valid_i (accept),
    .pop_ld_i        (pop_ld),
    .pop_st_i        (pop_st),
    .lsu_ctrl_o      (lsu_ctrl),
    .ready_o         (lsu_ready_o)
  );

  // ---------------------------------------------------------------------
  // Steer the queue head to the unit that owns the operation
  // ---------------------------------------------------------------------
  assign st_valid = lsu_ctrl.valid & lsu_pkg::op_is_store(lsu_ctrl.operation);
  assign ld_valid = lsu_ctrl.valid & ~lsu_pkg::op_is_store(lsu_ctrl.operation);

  load_unit i_load_unit (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .valid_i      (ld_valid),
    .lsu_ctrl_i   (lsu_ctrl),
    .pop_ld_o     (pop_ld),
    .mem_rd_req_o (mem_rd_req_o),
    .mem_rd_rsp_i (mem_rd_rsp_i),
    .result_o     (ld_result)
  );

  store_unit i_store_unit (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .valid_i      (st_valid),
    .lsu_ctrl_i   (lsu_ctrl),
    .pop_st_o     (pop_st),
    .mem_wr_req_o (mem_wr_req_o),
    .mem_wr_gnt_i (mem_wr_gnt_i),
    .result_o     (st_result)
  );

  // Output pipeline registers
  lsu_out_pipe #(.Depth(NrLoadPipeRegs)) i_pipe_load (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .d_i    (ld_result),
    .d_o    (load_o)
  );

  lsu_out_pipe #(.Depth(NrStorePipeRegs)) i_pipe_store (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .d_i    (st_result),
    .d_o    (store_o)
  );

endmodule

/* lsu_checker.sv */
// --------------------------------------------------------------------------
// LSU port checker
// Concurrent assertions on the memory ports and result streams
// --------------------------------------------------------------------------
module lsu_checker (
  input logic                 clk_i,
  input logic                 rst_ni,
  input logic                 lsu_ready_o,
  input lsu_pkg::lsu_result_t load_o,
  input lsu_pkg::lsu_result_t store_o,
  input lsu_pkg::mem_rd_req_t mem_rd_req_o,
  input lsu_pkg::mem_rd_rsp_t mem_rd_rsp_i,
  input lsu_pkg::mem_wr_req_t mem_wr_req_o,
  input logic                 mem_wr_gnt_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // Requests hold until granted
  rd_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_rd_req_o.req && !mem_rd_rsp_i.gnt |=> mem_rd_req_o.req && $stable(mem_rd_req_o.addr))
    else $error("read request changed before grant");

  wr_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_wr_req_o.req && !mem_wr_gnt_i |=> mem_wr_req_o.req && $stable(mem_wr_req_o))
    else $error("write request changed before grant");

  wr_be_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_wr_req_o.req |-> mem_wr_req_o.be != '0)
    else $error("write request without byte enables");

  ld_cause_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    load_o.valid && load_o.ex.valid |-> load_o.ex.cause == lsu_pkg::LD_ADDR_MISALIGNED)
    else $error("load result carries a store cause");

  st_cause_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    store_o.valid && store_o.ex.valid |-> store_o.ex.cause == lsu_pkg::ST_ADDR_MISALIGNED)
    else $error("store result carries a load cause");

  ready_after_reset_a: assert property (@(posedge clk_i) $rose(rst_ni) |-> lsu_ready_o)
    else $error("not ready after reset");

endmodule

bind load_store_unit lsu_checker i_lsu_checker (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .lsu_ready_o  (lsu_ready_o),
  .load_o       (load_o),
  .store_o      (store_o),
  .mem_rd_req_o (mem_rd_req_o),
  .mem_rd_rsp_i (mem_rd_rsp_i),
  .mem_wr_req_o (mem_wr_req_o),
  .mem_wr_gnt_i (mem_wr_gnt_i)
);

/* tb_load_store_unit.sv */
// --------------------------------------------------------------------------
// Load/store unit testbench
// File driven stimulus, random grants, memory model and in-order scoreboard
// --------------------------------------------------------------------------
module tb_load_store_unit;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int MaxOps = 64;

  typedef struct packed {
    lsu_pkg::trans_id_t trans_id;
    lsu_pkg::word_t     result;
    lsu_pkg::cause_t    cause;
    lsu_pkg::word_t     tval;
  } expect_t;

  logic                 clk_i;
  logic                 rst_ni;
  logic                 lsu_valid_i;
  lsu_pkg::fu_data_t    fu_data_i;
  logic                 lsu_ready_o;
  lsu_pkg::lsu_result_t load_o;
  lsu_pkg::lsu_result_t store_o;
  lsu_pkg::mem_rd_req_t mem_rd_req_o;
  lsu_pkg::mem_rd_rsp_t mem_rd_rsp_i;
  lsu_pkg::mem_wr_req_t mem_wr_req_o;
  logic                 mem_wr_gnt_i;

  logic [31:0]  stim [6*MaxOps];
  logic [7:0]   mem [256];
  expect_t      ld_exp_q [$];
  expect_t      st_exp_q [$];
  int           n_ops;
  logic [31:0]  lcg_state;

  load_store_unit #(
    .NrLoadPipeRegs  (1),
    .NrStorePipeRegs (1)
  ) i_dut (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .lsu_valid_i  (lsu_valid_i),
    .fu_data_i    (fu_data_i),
    .lsu_ready_o  (lsu_ready_o),
    .load_o       (load_o),
    .store_o      (store_o),
    .mem_rd_req_o (mem_rd_req_o),
    .mem_rd_rsp_i (mem_rd_rsp_i),
    .mem_wr_req_o (mem_wr_req_o),
    .mem_wr_gnt_i (mem_wr_gnt_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Grant roughly three cycles out of four
  function automatic logic random_grant();
    logic [31:0] r;
    r = lcg_next();
    return r[17:16] != 2'b00;
  endfunction

  task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
      $display("*** FAILED ***");
      $fatal(1, "check failed");
    end
  endtask

  task automatic check_result(input string kind, input lsu_pkg::lsu_result_t res,
                              inout expect_t exp_q [$]);
    expect_t e;
    if (exp_q.size() == 0) begin
      $display("Unexpected %s result at %0t ns with nothing outstanding", kind, $time);
      $display("*** FAILED ***");
      $fatal(1, "unexpected result");
    end
    e = exp_q.pop_front();
    compare({kind, " trans_id"}, 32'(res.trans_id), 32'(e.trans_id));
    compare({kind, " result"}, res.result, e.result);
    compare({kind, " ex.valid"}, 32'(res.ex.valid), 32'(e.cause != '0));
    compare({kind, " cause"}, 32'(res.ex.cause), 32'(e.cause));
    compare({kind, " tval"}, res.ex.tval, e.tval);
  endtask

  // Enabled bytes land in the addressed word
  task automatic apply_write(input lsu_pkg::mem_wr_req_t wr);
    logic [7:0] base;
    base = {wr.addr[7:2], 2'b00};
    for (int b = 0; b < 4; b++) begin
      if (wr.be[b]) begin
        mem[base + 8'(b)] = wr.wdata[8*b +: 8];
      end
    end
  endtask

  function automatic logic [31:0] read_word(input logic [31:0] addr);
    logic [7:0] base;
    base = {addr[7:2], 2'b00};
    return {mem[base + 8'd3], mem[base + 8'd2], mem[base + 8'd1], mem[base]};
  endfunction

  // --------------------------------------------------------------------------
  // Stimulus, memory model and scoreboard, all stepped on the falling edge
  // --------------------------------------------------------------------------
  initial begin : main
    int          op_idx;
    int          base;
    logic [2:0]  next_id;
    logic        rd_pending;
    logic [31:0] rd_addr;
    expect_t     e;

    rst_ni       = 1'b0;
    lsu_valid_i  = 1'b0;
    fu_data_i    = '0;
    mem_rd_rsp_i = '0;
    mem_wr_gnt_i = 1'b0;
    lcg_state    = 32'd5369;
    op_idx       = 0;
    next_id      = '0;
    rd_pending   = 1'b0;
    rd_addr      = '0;
    for (int i = 0; i < 256; i++) begin
      mem[i] = 8'(i) ^ 8'hA5;
    end
    for (int i = 0; i < 6*MaxOps; i++) begin
      stim[i] = '1;
    end
    $readmemh("lsu_stim.txt", stim);
    n_ops = 0;
    while (n_ops < MaxOps && stim[6*n_ops] !== '1) begin
      n_ops++;
    end

    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    while (op_idx < n_ops || ld_exp_q.size() != 0 || st_exp_q.size() != 0) begin
      // Read data of last cycle's grant
      if (rd_pending) begin
        mem_rd_rsp_i.rdata = read_word(rd_addr);
      end
      mem_rd_rsp_i.gnt = random_grant();
      mem_wr_gnt_i     = random_grant();
      if (op_idx < n_ops) begin
        base                = 6 * op_idx;
        lsu_valid_i         = 1'b1;
        fu_data_i.operation = lsu_pkg::lsu_op_e'(stim[base][2:0]);
        fu_data_i.operand_a = stim[base+1];
        fu_data_i.imm       = stim[base+2];
        fu_data_i.operand_b = stim[base+3];
        fu_data_i.trans_id  = next_id;
      end else begin
        lsu_valid_i = 1'b0;
      end
      #1;
      // Handshakes that complete at the coming rising edge
      rd_pending = mem_rd_req_o.req && mem_rd_rsp_i.gnt;
      rd_addr    = mem_rd_req_o.addr;
      if (mem_wr_req_o.req && mem_wr_gnt_i) begin
        apply_write(mem_wr_req_o);
      end
      if (lsu_valid_i && lsu_ready_o) begin
        e.trans_id = next_id;
        e.result   = stim[base+4];
        e.cause    = stim[base+5][3:0];
        e.tval     = (e.cause != '0) ? fu_data_i.operand_a + fu_data_i.imm : '0;
        if (lsu_pkg::op_is_store(fu_data_i.operation)) begin
          st_exp_q.push_back(e);
        end else begin
          ld_exp_q.push_back(e);
        end
        op_idx++;
        next_id++;
      end
      if (load_o.valid) begin
        check_result("load", load_o, ld_exp_q);
      end
      if (store_o.valid) begin
        check_result("store", store_o, st_exp_q);
      end
      @(negedge clk_i);
    end

    $display("*** PASSED ***");
    $finish;
  end

  // Watchdog scaled to the number of operations
  initial begin : watchdog
    #1;
    repeat (200 * n_ops + 20) @(posedge clk_i);
    $display("Timeout: not all results arrived in time");
    $display("*** FAILED ***");
    $fatal(1, "timeout");
  end

endmodule

/* lsu_stim.txt */
// op(0 LB,1 LBU,2 LH,3 LHU,4 LW,5 SB,6 SH,7 SW) operand_a imm operand_b
// expected result, expected cause (0 none)
4 00000010 00000000 00000000 B6B7B4B5 0
0 00000010 00000000 00000000 FFFFFFB5 0
0 00000010 00000001 00000000 FFFFFFB4 0
1 00000010 00000002 00000000 000000B7 0
1 00000010 00000003 00000000 000000B6 0
2 00000010 00000000 00000000 FFFFB4B5 0
3 00000010 00000002 00000000 0000B6B7 0
2 00000020 00000002 00000000 FFFF8687 0
3 00000020 00000000 00000000 00008485 0
0 00000080 00000001 00000000 00000024 0
2 00000080 00000002 00000000 00002627 0
4 00000080 00000000 00000000 26272425 0
// Negative immediates
4 00000088 FFFFFFF8 00000000 26272425 0
0 00000090 FFFFFFEF 00000000 FFFFFFDA 0
1 00000090 FFFFFFE7 00000000 000000D2 0
0 00000080 FFFFFFF7 00000000 FFFFFFD2 0
// Stores followed by loads of the same word
5 00000040 00000001 0000005A 00000000 0
4 00000040 00000000 00000000 E6E75AE5 0
6 00000040 00000002 00001234 00000000 0
4 00000040 00000000 00000000 12345AE5 0
7 00000050 00000000 DEADBEEF 00000000 0
4 00000050 00000000 00000000 DEADBEEF 0
0 00000050 00000003 00000000 FFFFFFDE 0
3 00000050 00000002 00000000 0000DEAD 0
5 00000050 00000002 FFFFFF77 00000000 0
4 00000050 00000000 00000000 DE77BEEF 0
7 000000F4 FFFFFFFC 0BADF00D 00000000 0
4 000000F0 00000000 00000000 0BADF00D 0
2 000000F0 00000002 00000000 00000BAD 0
// Misaligned accesses, memory stays untouched
2 00000061 00000000 00000000 00000000 4
4 00000060 00000002 00000000 00000000 4
6 00000060 00000003 0000FFFF 00000000 6
7 00000060 00000001 12345678 00000000 6
4 00000060 00000000 00000000 C6C7C4C5 0
3 00000020 FFFFFFFF 00000000 00000000 4
7 00000070 FFFFFFFE 00000000 00000000 6
4 0000006C 00000000 00000000 CACBC8C9 0

/* load_store_unit.f */
lsu_pkg.sv
lsu_agu.sv
lsu_bypass.sv
load_unit.sv
store_unit.sv
lsu_out_pipe.sv
load_store_unit.sv
lsu_checker.sv
tb_load_store_unit.sv

/* Makefile */
TOP := tb_load_store_unit

.PHONY: compile run clean

compile:
	verilator --binary --assert -f load_store_unit.f --top-module $(TOP)

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
